// ==== all.f ====
rtl/aesTypesPkg.sv
rtl/gfMathPkg.sv
rtl/aesControl.sv
rtl/keySchedule.sv
rtl/encRound.sv
rtl/decRound.sv
rtl/aesDatapath.sv
rtl/aesCore.sv
bench/aesCore_checker.sv
bench/aesMonitor.sv
bench/aesTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the AES testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aesTb -f all.f -o aesSim --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/aesSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0

// ==== bench/aesTb.sv ====
`timescale 1ns/1ps

module aesTb
    import aesTypesPkg::*, gfMathPkg::*;
();

    localparam int numRandom = 20;
    // Known vectors, random encryptions, round trips and the busy test
    localparam int numBlocks = 2 + numRandom + 2 * numRandom + 1;
    localparam int watchdogCycles = numBlocks * (aesLatency + 4) + 20;

    logic      clk;
    logic      rstN;
    logic      start;
    logic      decrypt;
    aesBlock_t key;
    aesBlock_t dataIn;
    aesBlock_t dataOut;
    logic      busy;
    logic      done;
    integer    seed;
    aesBlock_t randKey;
    aesBlock_t randData;
    aesBlock_t cipher;

    aesCore dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .decrypt (decrypt),
        .key     (key),
        .dataIn  (dataIn),
        .dataOut (dataOut),
        .busy    (busy),
        .done    (done)
    );

    aesMonitor monitor0 (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .dataOut (dataOut)
    );

    always #10 clk = ~clk;

    // --------------------------------------------------
    // Reference cipher where byte 4c+r is row r of column c
    // --------------------------------------------------
    function automatic aesBlock_t aesRef(aesBlock_t keyIn, aesBlock_t plain);
        aesByte_t  s [16];
        aesByte_t  t [16];
        aesByte_t  rk [16];
        aesByte_t  rcon;
        aesBlock_t res;
        rcon = 8'h01;
        for (int i = 0; i < 16; i++) begin
            rk[i] = keyIn[127 - 8*i -: 8];
            s[i] = plain[127 - 8*i -: 8] ^ rk[i];
        end
        for (int rnd = 1; rnd <= numRounds; rnd++) begin
            // SubBytes and ShiftRows in one pass
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    t[4*c + r] = sbox(s[4*((c + r) % 4) + r]);
                end
            end
            for (int c = 0; c < 4; c++) begin
                for (int r = 0; r < 4; r++) begin
                    if (rnd == numRounds) begin
                        s[4*c + r] = t[4*c + r];
                    end else begin
                        s[4*c + r] = xtime(t[4*c + r]) ^ xtime(t[4*c + (r + 1) % 4])
                            ^ t[4*c + (r + 1) % 4] ^ t[4*c + (r + 2) % 4]
                            ^ t[4*c + (r + 3) % 4];
                    end
                end
            end
            // Next round key from the rotated last word
            rk[0] = rk[0] ^ sbox(rk[13]) ^ rcon;
            rk[1] = rk[1] ^ sbox(rk[14]);
            rk[2] = rk[2] ^ sbox(rk[15]);
            rk[3] = rk[3] ^ sbox(rk[12]);
            for (int i = 4; i < 16; i++) begin
                rk[i] = rk[i] ^ rk[i - 4];
            end
            rcon = xtime(rcon);
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ rk[i];
            end
        end
        for (int i = 0; i < 16; i++) begin
            res[127 - 8*i -: 8] = s[i];
        end
        return res;
    endfunction

    function automatic aesBlock_t randomBlock();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // --------------------------------------------------
    // Stimulus tasks
    // --------------------------------------------------
    task automatic pulseStart(input logic dec, input aesBlock_t k, input aesBlock_t d);
        start = 1'b1;
        decrypt = dec;
        key = k;
        dataIn = d;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic waitDone();
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runBlock(input string name, input logic dec, input aesBlock_t k,
                            input aesBlock_t d, input aesBlock_t expected);
        monitor0.expectBlock(name, expected);
        pulseStart(dec, k, d);
        waitDone();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        decrypt = 1'b0;
        key = '0;
        dataIn = '0;
        seed = 32'h8ae9;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;
        monitor0.checkIdle("reset state");

        runBlock("known encrypt", 1'b0, 128'h000102030405060708090a0b0c0d0e0f,
            128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        runBlock("known decrypt", 1'b1, 128'h000102030405060708090a0b0c0d0e0f,
            128'h69c4e0d86a7b0430d8cdb78070b4c55a, 128'h00112233445566778899aabbccddeeff);

        for (int i = 0; i < numRandom; i++) begin
            randKey = randomBlock();
            randData = randomBlock();
            runBlock("random encrypt", 1'b0, randKey, randData, aesRef(randKey, randData));
        end

        for (int i = 0; i < numRandom; i++) begin
            randKey = randomBlock();
            randData = randomBlock();
            runBlock("round trip encrypt", 1'b0, randKey, randData, aesRef(randKey, randData));
            cipher = dataOut;
            runBlock("round trip decrypt", 1'b1, randKey, cipher, randData);
        end

        // Second start lands mid-block and must be dropped
        randKey = randomBlock();
        randData = randomBlock();
        monitor0.expectBlock("start while busy", aesRef(randKey, randData));
        pulseStart(1'b0, randKey, randData);
        repeat (5) begin
            @(posedge clk);
            #1;
        end
        pulseStart(1'b1, randomBlock(), randomBlock());
        waitDone();
        repeat (aesLatency + 4) begin
            @(posedge clk);
            #1;
        end
        monitor0.finalCheck();

        $display("errors: value %0d, protocol %0d", monitor0.valueErrors,
            monitor0.protocolErrors);
        if (monitor0.valueErrors + monitor0.protocolErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the run completed", watchdogCycles);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== bench/aesMonitor.sv ====
`timescale 1ns/1ps

module aesMonitor
    import aesTypesPkg::*;
(
    input logic      clk,
    input logic      rstN,
    input logic      start,
    input logic      busy,
    input logic      done,
    input aesBlock_t dataOut
);

    string     nameQ [$];
    aesBlock_t expQ [$];
    string     curName;
    aesBlock_t curExp;
    int        cycle = 0;
    int        startCycle = 0;
    int        valueErrors = 0;
    int        protocolErrors = 0;

    // Queue the expected result of the next block
    task automatic expectBlock(input string name, input aesBlock_t value);
        nameQ.push_back(name);
        expQ.push_back(value);
    endtask

    task automatic checkIdle(input string name);
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("error %s expected busy 0 done 0 actual busy %b done %b", name, busy, done);
            protocolErrors++;
        end
    endtask

    task automatic finalCheck();
        while (expQ.size() > 0) begin
            $display("%s: block never signalled done", nameQ.pop_front());
            void'(expQ.pop_front());
            protocolErrors++;
        end
    endtask

    // --------------------------------------------------
    // Compare on done
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rstN) begin
            cycle++;
            if (done) begin
                if (expQ.size() == 0) begin
                    $display("extra done with no block outstanding at cycle %0d", cycle);
                    protocolErrors++;
                end else begin
                    curName = nameQ.pop_front();
                    curExp = expQ.pop_front();
                    if (dataOut !== curExp) begin
                        $display("error %s expected %h actual %h", curName, curExp, dataOut);
                        valueErrors++;
                    end
                    // done is seen one edge after the edge that raised it
                    if (cycle - startCycle - 1 != aesLatency) begin
                        $display("%s: done came %0d edges after start instead of %0d",
                            curName, cycle - startCycle - 1, aesLatency);
                        protocolErrors++;
                    end
                end
            end
            if (start && !busy) begin
                startCycle = cycle;
            end
        end
    end

endmodule

// ==== bench/aesCore_checker.sv ====
`timescale 1ns/1ps

module aesCoreChecker
    import aesTypesPkg::*;
(
    input logic clk,
    input logic rstN,
    input logic start,
    input logic busy,
    input logic done
);

    // done is a single-cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
        else $error("done held high for more than one cycle");

    doneNotBusy: assert property (@(posedge clk) disable iff (!rstN) !(done && busy))
        else $error("done and busy high together");

    // Sampled one edge after the edge that raises done
    startToDone: assert property (@(posedge clk) disable iff (!rstN)
        (start && !busy) |-> ##(aesLatency + 1) done)
        else $error("done did not follow an accepted start at the expected edge");

    busyFall: assert property (@(posedge clk) disable iff (!rstN) $fell(busy) |-> $rose(done))
        else $error("busy fell without done rising");

endmodule

bind aesCore aesCoreChecker checker0 (
    .clk   (clk),
    .rstN  (rstN),
    .start (start),
    .busy  (busy),
    .done  (done)
);

// ==== rtl/aesCore.sv ====
`timescale 1ns/1ps

module aesCore
    import aesTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  logic      decrypt,
    input  aesBlock_t key,
    input  aesBlock_t dataIn,
    output aesBlock_t dataOut,
    output logic      busy,
    output logic      done
);

    aesCtrl_t  ctrl;
    aesBlock_t roundKey;

    aesControl control0 (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .decrypt (decrypt),
        .ctrl    (ctrl),
        .busy    (busy),
        .done    (done)
    );

    keySchedule keySchedule0 (
        .clk      (clk),
        .key      (key),
        .ctrl     (ctrl),
        .roundKey (roundKey)
    );

    aesDatapath datapath0 (
        .clk      (clk),
        .dataIn   (dataIn),
        .ctrl     (ctrl),
        .roundKey (roundKey),
        .state    (dataOut)
    );

endmodule

// ==== rtl/aesDatapath.sv ====
`timescale 1ns/1ps

module aesDatapath
    import aesTypesPkg::*;
(
    input  logic      clk,
    input  aesBlock_t dataIn,
    input  aesCtrl_t  ctrl,
    input  aesBlock_t roundKey,
    output aesBlock_t state
);

    aesBlock_t encOut;
    aesBlock_t decOut;

    encRound encRound0 (
        .stateIn   (state),
        .roundKey  (roundKey),
        .lastRound (ctrl.lastRound),
        .stateOut  (encOut)
    );

    decRound decRound0 (
        .stateIn   (state),
        .roundKey  (roundKey),
        .lastRound (ctrl.lastRound),
        .stateOut  (decOut)
    );

    // State register, held between blocks
    always_ff @(posedge clk) begin
        if (ctrl.loadData) begin
            state <= dataIn;
        end else if (ctrl.addInitial) begin
            state <= state ^ roundKey;
        end else if (ctrl.doRound) begin
            state <= ctrl.decrypt ? decOut : encOut;
        end
    end

endmodule

// ==== rtl/decRound.sv ====
`timescale 1ns/1ps

module decRound
    import aesTypesPkg::*, gfMathPkg::*;
(
    input  aesBlock_t stateIn,
    input  aesBlock_t roundKey,
    input  logic      lastRound,
    output aesBlock_t stateOut
);

    aesBlock_t shifted;
    aesBlock_t subbed;
    aesBlock_t keyed;

    assign shifted = invShiftRows(stateIn);

    for (genvar i = 0; i < 16; i++) begin : gInvSub
        assign subbed[8*i +: 8] = invSbox(shifted[8*i +: 8]);
    end

    assign keyed = subbed ^ roundKey;

    // Key goes in before InvMixColumns as in the plain inverse cipher
    assign stateOut = lastRound ? keyed : invMixColumns(keyed);

endmodule

// ==== rtl/encRound.sv ====
`timescale 1ns/1ps

module encRound
    import aesTypesPkg::*, gfMathPkg::*;
(
    input  aesBlock_t stateIn,
    input  aesBlock_t roundKey,
    input  logic      lastRound,
    output aesBlock_t stateOut
);

    aesBlock_t subbed;
    aesBlock_t shifted;
    aesBlock_t mixed;

    // SubBytes one column at a time
    for (genvar c = 0; c < 4; c++) begin : gSub
        assign subbed[32*c +: 32] = subWord(stateIn[32*c +: 32]);
    end

    assign shifted = shiftRows(subbed);

    // Final round has no MixColumns
    assign mixed = lastRound ? shifted : mixColumns(shifted);

    assign stateOut = mixed ^ roundKey;

endmodule

// ==== rtl/keySchedule.sv ====
`timescale 1ns/1ps

module keySchedule
    import aesTypesPkg::*, gfMathPkg::*;
(
    input  logic      clk,
    input  aesBlock_t key,
    input  aesCtrl_t  ctrl,
    output aesBlock_t roundKey
);

    aesBlock_t keyMem [numKeys];
    aesBlock_t lastKey;
    aesByte_t  rcon;
    aesWord_t  temp;
    aesBlock_t nextKey;

    // --------------------------------------------------
    // One expansion step from the latest key
    // --------------------------------------------------
    assign temp = subWord(rotWord(lastKey[31:0])) ^ {rcon, 24'h000000};

    // Each word is the running XOR of the words before it
    assign nextKey[127:96] = lastKey[127:96] ^ temp;
    assign nextKey[95:64] = lastKey[95:64] ^ lastKey[127:96] ^ temp;
    assign nextKey[63:32] = lastKey[63:32] ^ lastKey[95:64] ^ lastKey[127:96] ^ temp;
    assign nextKey[31:0] = lastKey[31:0] ^ lastKey[63:32] ^ lastKey[95:64]
        ^ lastKey[127:96] ^ temp;

    always_ff @(posedge clk) begin
        if (ctrl.loadData) begin
            keyMem[0] <= key;
            lastKey <= key;
            rcon <= 8'h01;
        end else if (ctrl.expandStep) begin
            keyMem[ctrl.keyIdx] <= nextKey;
            lastKey <= nextKey;
            // 01, 02, 04 ... 80, 1b, 36
            rcon <= xtime(rcon);
        end
    end

    // Combinational read of the selected slot
    assign roundKey = keyMem[ctrl.keyIdx];

endmodule

// ==== rtl/aesControl.sv ====
`timescale 1ns/1ps

module aesControl
    import aesTypesPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     start,
    input  logic     decrypt,
    output aesCtrl_t ctrl,
    output logic     busy,
    output logic     done
);

    phase_t    phase;
    roundIdx_t roundCnt;
    logic      dirReg;
    logic      accept;

    // Starts are only taken when idle
    assign accept = start && (phase == phaseIdle);

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= phaseIdle;
            roundCnt <= '0;
            dirReg <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                phaseIdle: begin
                    if (accept) begin
                        phase <= phaseExpand;
                        roundCnt <= 4'd1;
                        dirReg <= decrypt;
                    end
                end
                phaseExpand: begin
                    if (roundCnt == roundIdx_t'(numRounds)) begin
                        phase <= phaseInit;
                    end else begin
                        roundCnt <= roundCnt + 4'd1;
                    end
                end
                phaseInit: begin
                    phase <= phaseRound;
                    roundCnt <= 4'd1;
                end
                phaseRound: begin
                    if (roundCnt == roundIdx_t'(numRounds)) begin
                        phase <= phaseIdle;
                        done <= 1'b1;
                    end else begin
                        roundCnt <= roundCnt + 4'd1;
                    end
                end
                default: phase <= phaseIdle;
            endcase
        end
    end

    // --------------------------------------------------
    // Command decode
    // --------------------------------------------------
    always_comb begin
        ctrl = '0;
        ctrl.loadData = accept;
        ctrl.decrypt = dirReg;
        case (phase)
            phaseExpand: begin
                // Slot being written this cycle
                ctrl.expandStep = 1'b1;
                ctrl.keyIdx = roundCnt;
            end
            phaseInit: begin
                ctrl.addInitial = 1'b1;
                ctrl.keyIdx = dirReg ? roundIdx_t'(numRounds) : '0;
            end
            phaseRound: begin
                ctrl.doRound = 1'b1;
                ctrl.lastRound = (roundCnt == roundIdx_t'(numRounds));
                // Decryption walks the keys backwards
                ctrl.keyIdx = dirReg ? roundIdx_t'(numRounds) - roundCnt : roundCnt;
            end
            default: ;
        endcase
    end

    assign busy = (phase != phaseIdle);

endmodule

// ==== rtl/gfMathPkg.sv ====
package gfMathPkg;
    import aesTypesPkg::*;

    // --------------------------------------------------
    // GF(2^8) with polynomial x^8 + x^4 + x^3 + x + 1
    // --------------------------------------------------
    function automatic aesByte_t xtime(aesByte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aesByte_t gfMul(aesByte_t a, aesByte_t b);
        aesByte_t acc;
        aesByte_t p;
        acc = '0;
        p = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254 by repeated squaring so that zero maps to zero
    function automatic aesByte_t gfInv(aesByte_t a);
        aesByte_t sq;
        aesByte_t acc;
        sq = a;
        acc = 8'h01;
        for (int i = 1; i < 8; i++) begin
            sq = gfMul(sq, sq);
            acc = gfMul(acc, sq);
        end
        return acc;
    endfunction

    // Field inverse followed by the affine map
    function automatic aesByte_t sbox(aesByte_t a);
        aesByte_t inv;
        inv = gfInv(a);
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // Inverse affine map first, then the field inverse
    function automatic aesByte_t invSbox(aesByte_t a);
        aesByte_t y;
        y = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
        return gfInv(y);
    endfunction

    // --------------------------------------------------
    // Word and block helpers
    // --------------------------------------------------
    function automatic aesWord_t subWord(aesWord_t w);
        aesWord_t res;
        for (int i = 0; i < 4; i++) begin
            res[8*i +: 8] = sbox(w[8*i +: 8]);
        end
        return res;
    endfunction

    function automatic aesWord_t rotWord(aesWord_t w);
        return {w[23:0], w[31:24]};
    endfunction

    // Byte 4c+r is row r of column c at bits [127-8(4c+r) -: 8]
    function automatic aesBlock_t shiftRows(aesBlock_t s);
        aesBlock_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[127 - 8*(4*c + r) -: 8] = s[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
        return res;
    endfunction

    function automatic aesBlock_t invShiftRows(aesBlock_t s);
        aesBlock_t res;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                res[127 - 8*(4*((c + r) % 4) + r) -: 8] = s[127 - 8*(4*c + r) -: 8];
            end
        end
        return res;
    endfunction

    function automatic aesBlock_t mixColumns(aesBlock_t s);
        aesBlock_t res;
        aesWord_t col;
        for (int c = 0; c < 4; c++) begin
            col = s[127 - 32*c -: 32];
            for (int r = 0; r < 4; r++) begin
                // 2a0 + 3a1 + a2 + a3 rotated per row
                res[127 - 32*c - 8*r -: 8] = xtime(col[31 - 8*r -: 8])
                    ^ xtime(col[31 - 8*((r + 1) % 4) -: 8]) ^ col[31 - 8*((r + 1) % 4) -: 8]
                    ^ col[31 - 8*((r + 2) % 4) -: 8] ^ col[31 - 8*((r + 3) % 4) -: 8];
            end
        end
        return res;
    endfunction

    function automatic aesBlock_t invMixColumns(aesBlock_t s);
        aesBlock_t res;
        aesWord_t col;
        for (int c = 0; c < 4; c++) begin
            col = s[127 - 32*c -: 32];
            for (int r = 0; r < 4; r++) begin
                res[127 - 32*c - 8*r -: 8] = gfMul(col[31 - 8*r -: 8], 8'h0e)
                    ^ gfMul(col[31 - 8*((r + 1) % 4) -: 8], 8'h0b)
                    ^ gfMul(col[31 - 8*((r + 2) % 4) -: 8], 8'h0d)
                    ^ gfMul(col[31 - 8*((r + 3) % 4) -: 8], 8'h09);
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/aesTypesPkg.sv ====
package aesTypesPkg;

    // --------------------------------------------------
    // Data widths
    // --------------------------------------------------
    typedef logic [127:0] aesBlock_t;
    typedef logic [31:0]  aesWord_t;
    typedef logic [7:0]   aesByte_t;

    // Round number and key slot from 0 to 10
    typedef logic [3:0]   roundIdx_t;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    typedef enum logic [1:0] {
        phaseIdle,
        phaseExpand,
        phaseInit,
        phaseRound
    } phase_t;

    // Per-cycle commands from the FSM to the key schedule and datapath
    typedef struct packed {
        logic      expandStep;
        logic      loadData;
        logic      addInitial;
        logic      doRound;
        logic      lastRound;
        logic      decrypt;
        roundIdx_t keyIdx;
    } aesCtrl_t;

    // --------------------------------------------------
    // Timing
    // --------------------------------------------------
    localparam int numRounds = 10;
    localparam int numKeys = 11;

    // Start edge to done edge
    localparam int aesLatency = 21;

endpackage
